// ==== design/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [7:0]      wmask_t;

    // base opcodes, rv64i
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    // alu func3
    localparam logic [2:0] F3_ADD  = 3'b000; // also sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch func3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    typedef enum logic [2:0] {
        CLS_NONE, CLS_ALU, CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_JUMP, CLS_LUI
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    // encoding matches func3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_B = 2'b00, SIZE_H = 2'b01, SIZE_W = 2'b10, SIZE_D = 2'b11
    } mem_size_e;

endpackage

// ==== design/ex_ctrl_if.sv ====
`timescale 1ns/1ps

interface ex_ctrl_if import ex_pkg::*; ();

    op_class_e op_class;
    alu_op_e   alu_op;
    logic      is_word;  // rv64 *w variants
    br_cond_e  br_cond;
    mem_size_e mem_size;
    logic      reg_wen;

    modport dec (
        output op_class, alu_op, is_word, br_cond, mem_size, reg_wen
    );

    modport alu (input op_class, alu_op, is_word);

    modport br (input op_class, br_cond);

    modport agu (input op_class, mem_size);

endinterface

// ==== design/ex_decode.sv ====
`timescale 1ns/1ps

module ex_decode import ex_pkg::*; (
    input  inst_t          inst_i,
    input  logic           reg_wen_i,
    ex_ctrl_if.dec         ctrl
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       alt;      // func7 bit 5 (inst[30])

    assign opcode = inst_i[6:0];
    assign func3  = inst_i[14:12];
    assign alt    = inst_i[30];

    // sub only exists for register-register forms
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt_bit,
                                          input logic reg_form);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = (alt_bit && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt_bit ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl.op_class = CLS_NONE;
        ctrl.alu_op   = ALU_ADD;
        ctrl.is_word  = 1'b0;
        ctrl.br_cond  = BR_EQ;
        ctrl.mem_size = mem_size_e'(func3[1:0]);
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                ctrl.op_class = CLS_ALU;
                ctrl.alu_op   = f3_to_alu(func3, alt, opcode == OPC_OP);
            end
            OPC_OP_IMM_32, OPC_OP_32: begin
                if (func3 == F3_ADD || func3 == F3_SLL || func3 == F3_SR) begin
                    ctrl.op_class = CLS_ALU;
                    ctrl.is_word  = 1'b1;
                    ctrl.alu_op   = f3_to_alu(func3, alt, opcode == OPC_OP_32);
                end
            end
            OPC_BRANCH: begin
                ctrl.op_class = CLS_BRANCH;
                case (func3)
                    F3_BEQ:  ctrl.br_cond = BR_EQ;
                    F3_BNE:  ctrl.br_cond = BR_NE;
                    F3_BLT:  ctrl.br_cond = BR_LT;
                    F3_BGE:  ctrl.br_cond = BR_GE;
                    F3_BLTU: ctrl.br_cond = BR_LTU;
                    F3_BGEU: ctrl.br_cond = BR_GEU;
                    default: ctrl.op_class = CLS_NONE;
                endcase
            end
            OPC_LOAD: begin
                if (func3 != 3'b111)  // no unsigned double load
                    ctrl.op_class = CLS_LOAD;
            end
            OPC_STORE: begin
                if (!func3[2])
                    ctrl.op_class = CLS_STORE;
            end
            OPC_JAL:  ctrl.op_class = CLS_JUMP;
            OPC_JALR: ctrl.op_class = (func3 == F3_JALR) ? CLS_JUMP : CLS_NONE;
            OPC_LUI:  ctrl.op_class = CLS_LUI;
            OPC_AUIPC: begin
                ctrl.op_class = CLS_ALU;  // pc + imm as a plain add
                ctrl.alu_op   = ALU_ADD;
            end
            default: ctrl.op_class = CLS_NONE;
        endcase
    end

    // only these classes write back
    assign ctrl.reg_wen = reg_wen_i && (ctrl.op_class inside {CLS_ALU, CLS_LOAD,
                                                              CLS_JUMP, CLS_LUI});

endmodule

// ==== design/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
    input  word_t          op1_i,
    input  word_t          op2_i,
    ex_ctrl_if.alu         ctrl,
    output word_t          result_o
);

    word_t       res64;
    logic [31:0] res32;
    word_t       res_w;   // sign-extended word result

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  res64 = op1_i + op2_i;
            ALU_SUB:  res64 = op1_i - op2_i;
            ALU_SLL:  res64 = op1_i << op2_i[5:0];
            ALU_SLT:  res64 = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU: res64 = {{(XLEN-1){1'b0}}, op1_i < op2_i};
            ALU_XOR:  res64 = op1_i ^ op2_i;
            ALU_SRL:  res64 = op1_i >> op2_i[5:0];
            ALU_SRA:  res64 = $unsigned($signed(op1_i) >>> op2_i[5:0]);
            ALU_OR:   res64 = op1_i | op2_i;
            ALU_AND:  res64 = op1_i & op2_i;
            default:  res64 = '0;
        endcase
    end

    // word forms, only add/sub/shifts are decoded here
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: res32 = op1_i[31:0] + op2_i[31:0];
            ALU_SUB: res32 = op1_i[31:0] - op2_i[31:0];
            ALU_SLL: res32 = op1_i[31:0] << op2_i[4:0];
            ALU_SRL: res32 = op1_i[31:0] >> op2_i[4:0];
            ALU_SRA: res32 = $unsigned($signed(op1_i[31:0]) >>> op2_i[4:0]);
            default: res32 = res64[31:0];
        endcase
    end

    assign res_w = {{(XLEN-32){res32[31]}}, res32};

    always_comb begin
        case (ctrl.op_class)
            CLS_ALU:  result_o = ctrl.is_word ? res_w : res64;
            CLS_JUMP: result_o = op1_i + op2_i;  // link address, pc + 4
            CLS_LUI:  result_o = op2_i;          // imm already shifted
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== design/ex_branch.sv ====
`timescale 1ns/1ps

module ex_branch import ex_pkg::*; (
    input  word_t          op1_i,
    input  word_t          op2_i,
    input  word_t          base_addr_i,
    input  word_t          offset_addr_i,
    ex_ctrl_if.br          ctrl,
    output logic           taken_o,
    output word_t          target_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (op1_i == op2_i);
    assign lt_s = ($signed(op1_i) < $signed(op2_i));
    assign lt_u = (op1_i < op2_i);

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt_s;
            BR_GE:   cond = !lt_s;
            BR_LTU:  cond = lt_u;
            BR_GEU:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign taken_o  = (ctrl.op_class == CLS_JUMP) ||
                      (ctrl.op_class == CLS_BRANCH && cond);
    assign target_o = base_addr_i + offset_addr_i;  // pc+imm or rs1+imm

endmodule

// ==== design/ex_agu.sv ====
`timescale 1ns/1ps

module ex_agu import ex_pkg::*; (
    input  word_t          base_addr_i,
    input  word_t          offset_addr_i,
    input  word_t          op2_i,
    ex_ctrl_if.agu         ctrl,
    output logic           ren_o,
    output logic           wen_o,
    output word_t          addr_o,
    output word_t          wdata_o,
    output wmask_t         wmask_o
);

    assign addr_o = base_addr_i + offset_addr_i;
    assign ren_o  = (ctrl.op_class == CLS_LOAD);
    assign wen_o  = (ctrl.op_class == CLS_STORE);

    always_comb begin
        wdata_o = '0;
        wmask_o = '0;
        if (wen_o) begin
            case (ctrl.mem_size)
                SIZE_B: begin
                    wdata_o = {{(XLEN-8){1'b0}}, op2_i[7:0]};
                    wmask_o = 8'h01;
                end
                SIZE_H: begin
                    wdata_o = {{(XLEN-16){1'b0}}, op2_i[15:0]};
                    wmask_o = 8'h03;
                end
                SIZE_W: begin
                    wdata_o = {{(XLEN-32){1'b0}}, op2_i[31:0]};
                    wmask_o = 8'h0F;
                end
                default: begin  // double
                    wdata_o = op2_i;
                    wmask_o = 8'hFF;
                end
            endcase
        end
    end

endmodule

// ==== design/ex_out_reg.sv ====
`timescale 1ns/1ps

module ex_out_reg import ex_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  word_t     result_i,
    input  logic      taken_i,
    input  word_t     target_i,
    input  logic      ren_i,
    input  logic      wen_i,
    input  word_t     addr_i,
    input  word_t     wdata_i,
    input  wmask_t    wmask_i,
    input  reg_addr_t rd_addr_i,
    input  logic      reg_wen_i,
    output logic      jump_en_o,
    output word_t     jump_addr_o,
    output word_t     rd_wdata_o,
    output reg_addr_t rd_waddr_o,
    output logic      reg_wen_o,
    output logic      mem_ren_o,
    output word_t     mem_raddr_o,
    output logic      mem_wen_o,
    output word_t     mem_waddr_o,
    output word_t     mem_wdata_o,
    output wmask_t    mem_wmask_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            jump_en_o   <= 1'b0;
            jump_addr_o <= '0;
            rd_wdata_o  <= '0;
            rd_waddr_o  <= '0;
            reg_wen_o   <= 1'b0;
            mem_ren_o   <= 1'b0;
            mem_raddr_o <= '0;
            mem_wen_o   <= 1'b0;
            mem_waddr_o <= '0;
            mem_wdata_o <= '0;
            mem_wmask_o <= '0;
        end else begin
            jump_en_o   <= taken_i;
            jump_addr_o <= target_i;
            rd_wdata_o  <= result_i;
            rd_waddr_o  <= reg_wen_i ? rd_addr_i : '0;  // no stray rd on non-writes
            reg_wen_o   <= reg_wen_i;
            mem_ren_o   <= ren_i;
            mem_raddr_o <= ren_i ? addr_i : '0;
            mem_wen_o   <= wen_i;
            mem_waddr_o <= wen_i ? addr_i : '0;
            mem_wdata_o <= wdata_i;
            mem_wmask_o <= wmask_i;
        end
    end

    // one memory access per instruction
    a_rw_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(mem_ren_o && mem_wen_o));

endmodule

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  inst_t     inst_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  reg_addr_t rd_addr_i,
    input  logic      reg_wen_i,
    input  word_t     base_addr_i,
    input  word_t     offset_addr_i,
    output logic      jump_en_o,
    output word_t     jump_addr_o,
    output word_t     rd_wdata_o,
    output reg_addr_t rd_waddr_o,
    output logic      reg_wen_o,
    output logic      mem_ren_o,
    output word_t     mem_raddr_o,
    output logic      mem_wen_o,
    output word_t     mem_waddr_o,
    output word_t     mem_wdata_o,
    output wmask_t    mem_wmask_o
);

    ex_ctrl_if ctrl ();

    word_t  alu_result;
    logic   br_taken;
    word_t  br_target;
    logic   agu_ren;
    logic   agu_wen;
    word_t  agu_addr;
    word_t  agu_wdata;
    wmask_t agu_wmask;

    ex_decode u_decode (
        .inst_i    (inst_i),
        .reg_wen_i (reg_wen_i),
        .ctrl      (ctrl.dec)
    );

    ex_alu u_alu (
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .ctrl     (ctrl.alu),
        .result_o (alu_result)
    );

    ex_branch u_branch (
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .ctrl          (ctrl.br),
        .taken_o       (br_taken),
        .target_o      (br_target)
    );

    ex_agu u_agu (
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .op2_i         (op2_i),
        .ctrl          (ctrl.agu),
        .ren_o         (agu_ren),
        .wen_o         (agu_wen),
        .addr_o        (agu_addr),
        .wdata_o       (agu_wdata),
        .wmask_o       (agu_wmask)
    );

    // single pipeline register toward mem
    ex_out_reg u_out_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .result_i    (alu_result),
        .taken_i     (br_taken),
        .target_i    (br_target),
        .ren_i       (agu_ren),
        .wen_i       (agu_wen),
        .addr_i      (agu_addr),
        .wdata_i     (agu_wdata),
        .wmask_i     (agu_wmask),
        .rd_addr_i   (rd_addr_i),
        .reg_wen_i   (ctrl.reg_wen),
        .jump_en_o   (jump_en_o),
        .jump_addr_o (jump_addr_o),
        .rd_wdata_o  (rd_wdata_o),
        .rd_waddr_o  (rd_waddr_o),
        .reg_wen_o   (reg_wen_o),
        .mem_ren_o   (mem_ren_o),
        .mem_raddr_o (mem_raddr_o),
        .mem_wen_o   (mem_wen_o),
        .mem_waddr_o (mem_waddr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wmask_o (mem_wmask_o)
    );

endmodule

// ==== dv/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

    localparam int K_ALU64  = 0;
    localparam int K_ALU32  = 1;
    localparam int K_BRANCH = 2;
    localparam int K_JUMP   = 3;
    localparam int K_LOAD   = 4;
    localparam int K_STORE  = 5;
    localparam int DRAIN_LIMIT = 20;  // cycles

    typedef struct packed {
        logic      jump_en;
        word_t     jump_addr;
        word_t     rd_wdata;
        reg_addr_t rd_waddr;
        logic      reg_wen;
        logic      mem_ren;
        word_t     mem_raddr;
        logic      mem_wen;
        word_t     mem_waddr;
        word_t     mem_wdata;
        wmask_t    mem_wmask;
    } exp_t;

    logic clk, reset_i, reg_wen_i;
    inst_t inst_i;
    word_t op1_i, op2_i, base_addr_i, offset_addr_i;
    reg_addr_t rd_addr_i;
    logic jump_en_o, reg_wen_o, mem_ren_o, mem_wen_o;
    word_t jump_addr_o, rd_wdata_o, mem_raddr_o, mem_waddr_o, mem_wdata_o;
    reg_addr_t rd_waddr_o;
    wmask_t mem_wmask_o;

    exp_t exp_q[$];
    exp_t cur;
    bit cur_valid = 1'b0;
    bit hung = 1'b0;
    int errors = 0, checks = 0, tests_run = 0, tests_ok = 0;
    int br_cnt = 0, ld_cnt = 0, st_cnt = 0;  // walk through every func3
    logic [2:0] br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    ex_stage ex_stage_inst (.*);

    always #50 clk = ~clk;

    function automatic word_t rand64();
        return {$urandom, $urandom};
    endfunction

    // expected outputs from the ISA rules
    function automatic exp_t model_ex(input inst_t in, input word_t a, input word_t b,
                                      input word_t base, input word_t off,
                                      input reg_addr_t rd, input logic wen_in);
        exp_t e;
        logic [6:0] opc;
        logic [2:0] f3;
        logic alt;
        logic wb;
        logic [31:0] w;
        e = '0;
        opc = in[6:0];
        f3 = in[14:12];
        alt = in[30];
        wb = 1'b0;
        w = '0;
        e.jump_addr = base + off;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                wb = 1'b1;
                case (f3)
                    F3_ADD:  e.rd_wdata = (alt && opc == OPC_OP) ? a - b : a + b;
                    F3_SLL:  e.rd_wdata = a << b[5:0];
                    F3_SLT:  e.rd_wdata = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    F3_SLTU: e.rd_wdata = (a < b) ? 64'd1 : 64'd0;
                    F3_XOR:  e.rd_wdata = a ^ b;
                    F3_SR: begin
                        if (alt)
                            e.rd_wdata = $signed(a) >>> b[5:0];
                        else
                            e.rd_wdata = a >> b[5:0];
                    end
                    F3_OR:   e.rd_wdata = a | b;
                    default: e.rd_wdata = a & b;
                endcase
            end
            OPC_OP_32, OPC_OP_IMM_32: begin
                wb = 1'b1;
                case (f3)
                    F3_ADD: w = (alt && opc == OPC_OP_32) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                    F3_SLL: w = a[31:0] << b[4:0];
                    F3_SR: begin
                        if (alt)
                            w = $signed(a[31:0]) >>> b[4:0];
                        else
                            w = a[31:0] >> b[4:0];
                    end
                    default: wb = 1'b0;  // illegal word op
                endcase
                if (wb)
                    e.rd_wdata = {{32{w[31]}}, w};
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  e.jump_en = (a == b);
                    F3_BNE:  e.jump_en = (a != b);
                    F3_BLT:  e.jump_en = ($signed(a) < $signed(b));
                    F3_BGE:  e.jump_en = ($signed(a) >= $signed(b));
                    F3_BLTU: e.jump_en = (a < b);
                    F3_BGEU: e.jump_en = (a >= b);
                    default: ;
                endcase
            end
            OPC_LOAD: begin
                if (f3 != 3'b111) begin
                    wb = 1'b1;
                    e.mem_ren = 1'b1;
                    e.mem_raddr = base + off;
                end
            end
            OPC_STORE: begin
                if (!f3[2]) begin
                    e.mem_wen = 1'b1;
                    e.mem_waddr = base + off;
                    case (f3[1:0])
                        2'd0: {e.mem_wdata, e.mem_wmask} = {56'b0, b[7:0], 8'h01};
                        2'd1: {e.mem_wdata, e.mem_wmask} = {48'b0, b[15:0], 8'h03};
                        2'd2: {e.mem_wdata, e.mem_wmask} = {32'b0, b[31:0], 8'h0F};
                        default: {e.mem_wdata, e.mem_wmask} = {b, 8'hFF};
                    endcase
                end
            end
            OPC_JAL, OPC_JALR: begin
                if (opc == OPC_JAL || f3 == F3_JALR) begin
                    wb = 1'b1;
                    e.jump_en = 1'b1;
                    e.rd_wdata = a + b;  // link
                end
            end
            OPC_LUI: begin
                wb = 1'b1;
                e.rd_wdata = b;
            end
            OPC_AUIPC: begin
                wb = 1'b1;
                e.rd_wdata = a + b;
            end
            default: ;
        endcase
        e.reg_wen = wen_in && wb;
        e.rd_waddr = e.reg_wen ? rd : '0;
        return e;
    endfunction

    // random immediate bits with a legal func7 or shamt top
    function automatic inst_t encode(input logic [6:0] opc, input logic [2:0] f3,
                                     input logic alt);
        inst_t i;
        logic sub_sra;
        i = $urandom;
        i[6:0] = opc;
        i[14:12] = f3;
        sub_sra = alt && (f3 == F3_ADD || f3 == F3_SR);
        case (opc)
            OPC_OP, OPC_OP_32: i[31:25] = sub_sra ? 7'h20 : 7'h00;
            OPC_OP_IMM: begin
                if (f3 == F3_SLL || f3 == F3_SR)
                    i[31:26] = (alt && f3 == F3_SR) ? 6'h10 : 6'h00;
            end
            OPC_OP_IMM_32: begin
                if (f3 == F3_SLL || f3 == F3_SR)
                    i[31:25] = (alt && f3 == F3_SR) ? 7'h20 : 7'h00;
            end
            default: ;
        endcase
        return i;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("FAILED %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task automatic compare_outputs(input exp_t e);
        check_value("jump_en_o", e.jump_en, jump_en_o);
        check_value("jump_addr_o", e.jump_addr, jump_addr_o);
        check_value("rd_wdata_o", e.rd_wdata, rd_wdata_o);
        check_value("rd_waddr_o", e.rd_waddr, rd_waddr_o);
        check_value("reg_wen_o", e.reg_wen, reg_wen_o);
        check_value("mem_ren_o", e.mem_ren, mem_ren_o);
        check_value("mem_raddr_o", e.mem_raddr, mem_raddr_o);
        check_value("mem_wen_o", e.mem_wen, mem_wen_o);
        check_value("mem_waddr_o", e.mem_waddr, mem_waddr_o);
        check_value("mem_wdata_o", e.mem_wdata, mem_wdata_o);
        check_value("mem_wmask_o", e.mem_wmask, mem_wmask_o);
    endtask

    // pop at the edge and compare mid-cycle
    always begin
        @(posedge clk);
        if (exp_q.size() > 0) begin
            cur = exp_q.pop_front();
            cur_valid = 1'b1;
        end
        @(negedge clk);
        if (cur_valid) begin
            compare_outputs(cur);
            cur_valid = 1'b0;
        end
    end

    task automatic issue(input int kind);
        inst_t in;
        word_t a, b;
        logic [6:0] opc;
        logic [2:0] f3;
        int pick;
        a = rand64();
        b = rand64();
        f3 = $urandom_range(0, 7);
        pick = $urandom_range(0, 3);
        case (kind)
            K_ALU64: opc = pick[0] ? OPC_OP : OPC_OP_IMM;
            K_ALU32: begin
                opc = pick[0] ? OPC_OP_32 : OPC_OP_IMM_32;
                f3 = (pick[1]) ? F3_SR : ($urandom_range(0, 1) ? F3_SLL : F3_ADD);
            end
            K_BRANCH: begin
                opc = OPC_BRANCH;
                f3 = br_f3[br_cnt % 6];
                br_cnt++;
                if (pick == 0)
                    b = a;  // hit the equal case
            end
            K_JUMP: begin
                opc = (pick == 0) ? OPC_JAL : (pick == 1) ? OPC_JALR :
                      (pick == 2) ? OPC_LUI : OPC_AUIPC;
                if (pick == 1)
                    f3 = F3_JALR;
            end
            K_LOAD: begin
                opc = OPC_LOAD;
                f3 = ld_cnt % 7;
                ld_cnt++;
            end
            default: begin
                opc = OPC_STORE;
                f3 = st_cnt % 4;
                st_cnt++;
            end
        endcase
        in = encode(opc, f3, $urandom_range(0, 1));
        @(posedge clk);
        #1;
        inst_i = in;
        op1_i = a;
        op2_i = b;
        base_addr_i = rand64();
        offset_addr_i = rand64();
        rd_addr_i = $urandom;
        reg_wen_i = ($urandom_range(0, 3) != 0);
        exp_q.push_back(model_ex(in, a, b, base_addr_i, offset_addr_i, rd_addr_i, reg_wen_i));
    endtask

    task automatic drain();
        int n;
        @(posedge clk);
        #1;
        inst_i = '0;  // opcode 0 has no effect
        reg_wen_i = 1'b0;
        for (n = 0; n < DRAIN_LIMIT; n++) begin
            if (exp_q.size() == 0 && !cur_valid)
                break;
            @(posedge clk);
            #2;
        end
        if (n == DRAIN_LIMIT) begin
            hung = 1'b1;
            $display("timeout, results still pending after %0d cycles", DRAIN_LIMIT);
        end
    endtask

    task automatic report_test(input string name, input int err0, input int chk0);
        tests_run++;
        if (errors == err0) begin
            tests_ok++;
            $display("test %-10s pass, %0d checks", name, checks - chk0);
        end else begin
            $display("test %-10s fail, %0d mismatches", name, errors - err0);
        end
    endtask

    task automatic run_test(input string name, input int kind_lo, input int kind_hi,
                            input int count);
        int err0, chk0;
        err0 = errors;
        chk0 = checks;
        if (!hung) begin
            for (int n = 0; n < count; n++)
                issue($urandom_range(kind_lo, kind_hi));
            drain();
            report_test(name, err0, chk0);
        end
    endtask

    initial begin
        exp_t idle;
        void'($urandom(44));
        idle = '0;
        clk = 1'b0;
        reset_i = 1'b1;
        inst_i = '0;
        op1_i = '0;
        op2_i = '0;
        base_addr_i = '0;
        offset_addr_i = '0;
        rd_addr_i = '0;
        reg_wen_i = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(negedge clk);
        compare_outputs(idle);  // nothing issued yet
        report_test("reset", 0, 0);
        run_test("alu64", K_ALU64, K_ALU64, 80);
        run_test("alu32", K_ALU32, K_ALU32, 60);
        run_test("branch", K_BRANCH, K_BRANCH, 48);
        run_test("jump_upper", K_JUMP, K_JUMP, 40);
        run_test("load_store", K_LOAD, K_STORE, 56);
        run_test("mix", K_ALU64, K_STORE, 120);
        $display("tests run %0d, passing %0d, failing %0d, checks %0d, mismatches %0d",
                 tests_run, tests_ok, tests_run - tests_ok, checks, errors);
        if (errors == 0 && !hung)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== ex_stage.f ====
design/ex_pkg.sv
design/ex_ctrl_if.sv
design/ex_decode.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_agu.sv
design/ex_out_reg.sv
design/ex_stage.sv
dv/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - design/ex_pkg.sv
  - design/ex_ctrl_if.sv
  - design/ex_decode.sv
  - design/ex_alu.sv
  - design/ex_branch.sv
  - design/ex_agu.sv
  - design/ex_out_reg.sv
  - design/ex_stage.sv
  - target: test
    files:
      - dv/ex_stage_tb.sv
